//--- crt_test_pkg.sv
/*
 * Shared types and constants for the CRT sine test pattern generator.
 * Modules refer to these by scoped name, crt_test_pkg::name.
 * Widths follow the 10-bit CRT coordinate space and the 8-bit sine table.
 */

package crt_test_pkg;

    // ========================================
    // Types
    // ========================================

    // Screen coordinate, 0..1023
    typedef logic [9:0] coord_t;

    // Sine phase index, one full period is 256 steps
    typedef logic [7:0] phase_t;

    // Table sample, 128 marks the zero crossing
    typedef logic [7:0] sine_sample_t;

    // Signed distance of a trace point from its centre line
    typedef logic signed [9:0] sine_offset_t;

    // Phosphor intensity code
    typedef logic [2:0] brightness_t;

    // ========================================
    // Pattern constants
    // ========================================

    // Zero crossing of the sine samples
    localparam sine_sample_t SINE_MIDPOINT = 8'd128;

    // Intensity of each trace
    localparam brightness_t BRIGHT_PRIMARY = 3'd7;
    localparam brightness_t BRIGHT_SECONDARY = 3'd6;

    // Phase steps per quadrant of the 256-step period
    // The quarter table holds one more entry for the peak itself
    localparam int QUARTER_DEPTH = 64;

endpackage

//--- sine_quarter_rom.sv
/*
 * Combinational sine lookup for one trace.
 * Only a quarter wave is stored, the other three quadrants are folded onto it.
 * Output sample is 128 + 127*sin(2*pi*phase/256), rounded, in the range 1..255.
 */

`timescale 1ns/1ps

module sine_quarter_rom (
    input  crt_test_pkg::phase_t       i_phase,
    output crt_test_pkg::sine_sample_t o_sample
);

    // ========================================
    // Quarter-wave table
    // ========================================

    // Entry k is round(128 + 127*sin(k*pi/128)) for k = 0..64
    // Entry 64 is the positive peak
    localparam crt_test_pkg::sine_sample_t QUARTER_TABLE [0:64] = '{
        8'd128, 8'd131, 8'd134, 8'd137, 8'd140, 8'd144, 8'd147, 8'd150,
        8'd153, 8'd156, 8'd159, 8'd162, 8'd165, 8'd168, 8'd171, 8'd174,
        8'd177, 8'd179, 8'd182, 8'd185, 8'd188, 8'd191, 8'd193, 8'd196,
        8'd199, 8'd201, 8'd204, 8'd206, 8'd209, 8'd211, 8'd213, 8'd216,
        8'd218, 8'd220, 8'd222, 8'd224, 8'd226, 8'd228, 8'd230, 8'd232,
        8'd234, 8'd235, 8'd237, 8'd239, 8'd240, 8'd241, 8'd243, 8'd244,
        8'd245, 8'd246, 8'd248, 8'd249, 8'd250, 8'd250, 8'd251, 8'd252,
        8'd253, 8'd253, 8'd254, 8'd254, 8'd254, 8'd255, 8'd255, 8'd255,
        8'd255
    };

    // ========================================
    // Quadrant folding
    // ========================================

    // Top two phase bits select the quadrant
    logic [1:0] quadrant;
    // Position inside the quadrant
    logic [5:0] step;
    // Table address, 0..64
    logic [6:0] table_idx;
    logic [7:0] quarter_val;
    // One bit wider so the reflection can be checked before truncation
    logic [8:0] folded;

    always_comb begin
        quadrant = i_phase[7:6];
        step     = i_phase[5:0];

        // Odd quadrants run down the table from the peak
        if (quadrant[0]) begin
            table_idx = 7'(crt_test_pkg::QUARTER_DEPTH) - {1'b0, step};
        end else begin
            table_idx = {1'b0, step};
        end

        quarter_val = QUARTER_TABLE[table_idx];

        // Lower half-wave mirrors the sample around the midpoint
        // 2*128 - v gives 128 - (v - 128)
        if (quadrant[1]) begin
            folded = {crt_test_pkg::SINE_MIDPOINT, 1'b0} - {1'b0, quarter_val};
        end else begin
            folded = {1'b0, quarter_val};
        end
    end

    assign o_sample = folded[7:0];

    // ========================================
    // Checks
    // ========================================

    // Sample must stay strictly inside 1..255 in every quadrant
    // A zero would mean the reflection wrapped through 256
    always_comb begin
        if (!$isunknown(i_phase)) begin
            assert (folded >= 9'd1 && folded <= 9'd255)
                else $error("sine sample %0d out of range for phase %0d", folded, i_phase);
        end
    end

endmodule

//--- wave_phase_gen.sv
/*
 * Strobe divider, sweep counter and phase accumulator of one sine trace.
 * o_advance marks the strobes on which the trace moves one step.
 * RATE_LOG2 = 0 moves on every strobe, RATE_LOG2 = 2 on every fourth.
 */

`timescale 1ns/1ps

module wave_phase_gen #(
    parameter int PHASE_STEP = 4,
    parameter int RATE_LOG2  = 0
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_pixel_shift,
    output logic                 o_advance,
    output crt_test_pkg::phase_t o_phase,
    output crt_test_pkg::coord_t o_sweep
);

    // Divider needs at least one bit even when it never counts
    localparam int DIV_W = (RATE_LOG2 > 0) ? RATE_LOG2 : 1;
    // Terminal count of the divider
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'((1 << RATE_LOG2) - 1);

    logic [DIV_W-1:0]     div_q;
    crt_test_pkg::phase_t phase_q;
    crt_test_pkg::coord_t sweep_q;

    // Same-cycle advance on the strobe that hits terminal count
    assign o_advance = i_pixel_shift && (div_q == DIV_LAST);

    // ========================================
    // Divider and trace counters
    // ========================================

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            div_q   <= '0;
            phase_q <= '0;
            sweep_q <= '0;
        end else begin
            if (i_pixel_shift) begin
                if (div_q == DIV_LAST) begin
                    div_q <= '0;
                end else begin
                    div_q <= div_q + 1'b1;
                end
            end
            // Sweep wraps at 1024, phase wraps at 256
            if (o_advance) begin
                sweep_q <= sweep_q + 1'b1;
                phase_q <= phase_q + crt_test_pkg::phase_t'(PHASE_STEP);
            end
        end
    end

    assign o_phase = phase_q;
    assign o_sweep = sweep_q;

    // Trace can only move on a display strobe
    a_advance_on_strobe: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_advance |-> i_pixel_shift
    ) else $error("advance without pixel strobe");

endmodule

//--- wave_coord_stage.sv
/*
 * Coordinate registers of one sine trace.
 * On each advance Y takes the sweep, the offset takes sample - 128,
 * and X takes centre plus the previous offset.
 */

`timescale 1ns/1ps

module wave_coord_stage #(
    parameter crt_test_pkg::coord_t CENTER = 10'd512
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_advance,
    input  crt_test_pkg::sine_sample_t i_sample,
    input  crt_test_pkg::coord_t       i_sweep,
    output crt_test_pkg::coord_t       o_x,
    output crt_test_pkg::coord_t       o_y
);

    // Signed distance from the centre line, -128..127
    crt_test_pkg::sine_offset_t offset_q;
    crt_test_pkg::sine_offset_t offset_next;
    crt_test_pkg::coord_t       x_q;
    crt_test_pkg::coord_t       y_q;

    // Zero-extend the sample, then remove the midpoint
    assign offset_next = crt_test_pkg::sine_offset_t'({2'b00, i_sample})
                       - crt_test_pkg::sine_offset_t'({2'b00, crt_test_pkg::SINE_MIDPOINT});

    // ========================================
    // Two-step coordinate pipeline
    // ========================================

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            offset_q <= '0;
            x_q      <= CENTER;
            y_q      <= '0;
        end else if (i_advance) begin
            y_q      <= i_sweep;
            offset_q <= offset_next;
            // Two's complement add, negative offsets wrap back below centre
            x_q      <= CENTER + crt_test_pkg::coord_t'(offset_q);
        end
    end

    assign o_x = x_q;
    assign o_y = y_q;

    // X band is set by the ROM range together with this stage's centre
    a_x_in_band: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (int'(o_x) >= int'(CENTER) - 128) && (int'(o_x) <= int'(CENTER) + 127)
    ) else $error("X %0d outside band around centre %0d", o_x, CENTER);

endmodule

//--- pixel_alternator.sv
/*
 * Output selector that interleaves the two traces.
 * The select flips on every pixel strobe, starting on the primary trace.
 * Coordinates and brightness are muxed combinationally from registers.
 */

`timescale 1ns/1ps

module pixel_alternator (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_pixel_shift,
    input  crt_test_pkg::coord_t      i_primary_x,
    input  crt_test_pkg::coord_t      i_primary_y,
    input  crt_test_pkg::coord_t      i_secondary_x,
    input  crt_test_pkg::coord_t      i_secondary_y,
    output crt_test_pkg::coord_t      o_x,
    output crt_test_pkg::coord_t      o_y,
    output crt_test_pkg::brightness_t o_brightness
);

    // Which trace is on the beam
    typedef enum logic {
        SEL_PRIMARY   = 1'b0,
        SEL_SECONDARY = 1'b1
    } trace_sel_t;

    trace_sel_t sel_q;

    // ========================================
    // Trace select toggle
    // ========================================

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sel_q <= SEL_PRIMARY;
        end else if (i_pixel_shift) begin
            sel_q <= (sel_q == SEL_PRIMARY) ? SEL_SECONDARY : SEL_PRIMARY;
        end
    end

    // Output mux, brightness follows the routed trace
    always_comb begin
        if (sel_q == SEL_SECONDARY) begin
            o_x          = i_secondary_x;
            o_y          = i_secondary_y;
            o_brightness = crt_test_pkg::BRIGHT_SECONDARY;
        end else begin
            o_x          = i_primary_x;
            o_y          = i_primary_y;
            o_brightness = crt_test_pkg::BRIGHT_PRIMARY;
        end
    end

    // Trace registers upstream only move on strobes, so idle cycles hold the beam
    a_hold_when_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_pixel_shift |=> ($stable(o_x) && $stable(o_y) && $stable(o_brightness))
    ) else $error("pixel output moved without a strobe");

endmodule

//--- sine_pattern_top.sv
/*
 * CRT sine test pattern generator, top level.
 * Two sine traces advance on i_pixel_shift and are interleaved per strobe.
 * o_valid mirrors i_enable; generation runs whether or not it is enabled.
 */

`timescale 1ns/1ps

module sine_pattern_top #(
    parameter crt_test_pkg::coord_t PRIMARY_CENTER       = 10'd512,
    parameter crt_test_pkg::coord_t SECONDARY_CENTER     = 10'd612,
    parameter int                   PRIMARY_PHASE_STEP   = 4,
    parameter int                   SECONDARY_PHASE_STEP = 2,
    parameter int                   PRIMARY_RATE_LOG2    = 0,
    parameter int                   SECONDARY_RATE_LOG2  = 2
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_enable,
    input  logic                      i_pixel_shift,
    output crt_test_pkg::coord_t      o_x,
    output crt_test_pkg::coord_t      o_y,
    output crt_test_pkg::brightness_t o_brightness,
    output logic                      o_valid
);

    // Primary trace chain
    logic                       primary_advance;
    crt_test_pkg::phase_t       primary_phase;
    crt_test_pkg::coord_t       primary_sweep;
    crt_test_pkg::sine_sample_t primary_sample;
    crt_test_pkg::coord_t       primary_x;
    crt_test_pkg::coord_t       primary_y;

    // Secondary trace chain
    logic                       secondary_advance;
    crt_test_pkg::phase_t       secondary_phase;
    crt_test_pkg::coord_t       secondary_sweep;
    crt_test_pkg::sine_sample_t secondary_sample;
    crt_test_pkg::coord_t       secondary_x;
    crt_test_pkg::coord_t       secondary_y;

    // ========================================
    // Primary trace
    // ========================================

    wave_phase_gen #(
        .PHASE_STEP (PRIMARY_PHASE_STEP),
        .RATE_LOG2  (PRIMARY_RATE_LOG2)
    ) u_primary_phase (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pixel_shift (i_pixel_shift),
        .o_advance     (primary_advance),
        .o_phase       (primary_phase),
        .o_sweep       (primary_sweep)
    );

    sine_quarter_rom u_primary_rom (
        .i_phase  (primary_phase),
        .o_sample (primary_sample)
    );

    wave_coord_stage #(
        .CENTER (PRIMARY_CENTER)
    ) u_primary_coord (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (primary_advance),
        .i_sample  (primary_sample),
        .i_sweep   (primary_sweep),
        .o_x       (primary_x),
        .o_y       (primary_y)
    );

    // ========================================
    // Secondary trace, slower rate
    // ========================================

    wave_phase_gen #(
        .PHASE_STEP (SECONDARY_PHASE_STEP),
        .RATE_LOG2  (SECONDARY_RATE_LOG2)
    ) u_secondary_phase (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pixel_shift (i_pixel_shift),
        .o_advance     (secondary_advance),
        .o_phase       (secondary_phase),
        .o_sweep       (secondary_sweep)
    );

    sine_quarter_rom u_secondary_rom (
        .i_phase  (secondary_phase),
        .o_sample (secondary_sample)
    );

    wave_coord_stage #(
        .CENTER (SECONDARY_CENTER)
    ) u_secondary_coord (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (secondary_advance),
        .i_sample  (secondary_sample),
        .i_sweep   (secondary_sweep),
        .o_x       (secondary_x),
        .o_y       (secondary_y)
    );

    // ========================================
    // Interleave onto the beam
    // ========================================

    pixel_alternator u_alternator (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pixel_shift (i_pixel_shift),
        .i_primary_x   (primary_x),
        .i_primary_y   (primary_y),
        .i_secondary_x (secondary_x),
        .i_secondary_y (secondary_y),
        .o_x           (o_x),
        .o_y           (o_y),
        .o_brightness  (o_brightness)
    );

    // Valid is a pure pass-through of the enable level
    assign o_valid = i_enable;

endmodule

//--- tb_sine_model.svh
/*
 * Reference model and compare tasks for the sine pattern testbench.
 * Included inside the testbench module. It tracks both traces and the
 * output select from the strobe rules, with its own sine table.
 */
`ifndef TB_SINE_MODEL_SVH
`define TB_SINE_MODEL_SVH

// ========================================
// Model state
// ========================================

localparam real PI = 3.14159265358979;

// Index 0 is the primary trace, index 1 the secondary trace
localparam int TRACE_CENTER [2] = '{512, 612};
localparam int TRACE_STEP   [2] = '{4, 2};
// Strobes per advance
localparam int TRACE_RATE   [2] = '{1, 4};
localparam crt_test_pkg::brightness_t EXP_BRIGHT [2] = '{3'd7, 3'd6};

crt_test_pkg::phase_t model_phase  [2];
crt_test_pkg::coord_t model_sweep  [2];
crt_test_pkg::coord_t model_x      [2];
crt_test_pkg::coord_t model_y      [2];
int                   model_offset [2];
int                   model_div    [2];
// Trace currently routed to the outputs
int                   model_sel;

// Ideal sample, 128 + 127*sin(2*pi*i/256) rounded to nearest
function automatic int ref_sine(input int idx);
    real v;
    v = 128.0 + 127.0 * $sin(2.0 * PI * real'(idx) / 256.0);
    return $rtoi(v + 0.5);
endfunction

task automatic reset_model();
    model_sel = 0;
    for (int t = 0; t < 2; t++) begin
        model_phase[t]  = '0;
        model_sweep[t]  = '0;
        model_x[t]      = crt_test_pkg::coord_t'(TRACE_CENTER[t]);
        model_y[t]      = '0;
        model_offset[t] = 0;
        model_div[t]    = 0;
    end
endtask

// One pixel strobe applied to both traces and the select
task automatic step_model();
    for (int t = 0; t < 2; t++) begin
        if (model_div[t] == TRACE_RATE[t] - 1) begin
            // X takes the old offset, offset takes the sample of the old phase
            model_x[t]      = crt_test_pkg::coord_t'(TRACE_CENTER[t] + model_offset[t]);
            model_offset[t] = ref_sine(int'(model_phase[t])) - 128;
            model_y[t]      = model_sweep[t];
            model_sweep[t]  = model_sweep[t] + 10'd1;
            model_phase[t]  = model_phase[t] + crt_test_pkg::phase_t'(TRACE_STEP[t]);
            model_div[t]    = 0;
        end else begin
            model_div[t] = model_div[t] + 1;
        end
    end
    model_sel = 1 - model_sel;
endtask

// ========================================
// Compare tasks
// ========================================

task automatic check_coord(input crt_test_pkg::coord_t actual,
                           input crt_test_pkg::coord_t expected, input string what);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED at %0t: %s expected %0d, got %0d",
                            $time, what, expected, actual));
    end
endtask

task automatic check_brightness(input crt_test_pkg::brightness_t actual,
                                input crt_test_pkg::brightness_t expected);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED at %0t: brightness expected %0d, got %0d",
                            $time, expected, actual));
    end
endtask

task automatic check_valid(input logic actual, input logic expected);
    if (actual !== expected) begin
        abort_run($sformatf("FAILED at %0t: valid expected %0b, got %0b",
                            $time, expected, actual));
    end
endtask

`endif

//--- tb_sine_pattern.sv
/*
 * Testbench for the CRT sine pattern generator.
 * Applies a table of strobe bursts with random idle gaps and checks every
 * output against the reference model after each clock edge.
 */

`timescale 1ns/1ps

module tb_sine_pattern;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS     = 6;
    localparam int SEED         = 12473;

    // Enable level, number of strobes, largest idle gap between strobes
    typedef struct packed {
        logic        enable;
        logic [15:0] strobes;
        logic [7:0]  max_gap;
    } stim_row_t;

    // Over 1024 strobes in total so the primary sweep wraps
    stim_row_t stim_table [NUM_ROWS] = '{
        '{1'b1, 16'd300, 8'd0},
        '{1'b0, 16'd200, 8'd3},
        '{1'b1, 16'd400, 8'd1},
        '{1'b0, 16'd100, 8'd0},
        '{1'b1, 16'd250, 8'd2},
        '{1'b0, 16'd40,  8'd5}
    };

    logic                      i_clk = 1'b0;
    logic                      i_rst_n;
    logic                      i_enable;
    logic                      i_pixel_shift;
    crt_test_pkg::coord_t      o_x;
    crt_test_pkg::coord_t      o_y;
    crt_test_pkg::brightness_t o_brightness;
    logic                      o_valid;
    int                        error_count = 0;

    sine_pattern_top #(
        .PRIMARY_CENTER       (10'd512),
        .SECONDARY_CENTER     (10'd612),
        .PRIMARY_PHASE_STEP   (4),
        .SECONDARY_PHASE_STEP (2),
        .PRIMARY_RATE_LOG2    (0),
        .SECONDARY_RATE_LOG2  (2)
    ) u_sine_pattern_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_pixel_shift (i_pixel_shift),
        .o_x           (o_x),
        .o_y           (o_y),
        .o_brightness  (o_brightness),
        .o_valid       (o_valid)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic abort_run(input string reason);
        error_count = error_count + 1;
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    `include "tb_sine_model.svh"

    // ========================================
    // Stimulus helpers
    // ========================================

    // All outputs against the model for the selected trace
    task automatic check_outputs(input logic exp_valid);
        check_coord(o_x, model_x[model_sel], model_sel ? "secondary X" : "primary X");
        check_coord(o_y, model_y[model_sel], model_sel ? "secondary Y" : "primary Y");
        check_brightness(o_brightness, EXP_BRIGHT[model_sel]);
        check_valid(o_valid, exp_valid);
    endtask

    // Strobe for one cycle, then idle for a random gap
    task automatic apply_strobe(input logic enable, input int max_gap);
        int gap;
        gap = int'($urandom_range(max_gap, 0));
        i_enable      = enable;
        i_pixel_shift = 1'b1;
        @(negedge i_clk);
        step_model();
        check_outputs(enable);
        i_pixel_shift = 1'b0;
        // Idle cycles must hold every output
        repeat (gap) begin
            @(negedge i_clk);
            check_outputs(enable);
        end
    endtask

    // Worst case of every strobe taking its full gap plus slack
    function automatic longint watchdog_limit_ns();
        longint total;
        total = longint'((RESET_CYCLES + 10) * CLK_PERIOD);
        foreach (stim_table[r]) begin
            total += longint'(stim_table[r].strobes)
                   * (longint'(stim_table[r].max_gap) + 2) * CLK_PERIOD;
        end
        return total + 1000;
    endfunction

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(SEED));
        i_rst_n       = 1'b0;
        i_enable      = 1'b0;
        i_pixel_shift = 1'b0;
        reset_model();

        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;

        // Reset state holds until the first strobe
        repeat (3) begin
            @(negedge i_clk);
            check_outputs(1'b0);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int s = 0; s < int'(stim_table[r].strobes); s++) begin
                apply_strobe(stim_table[r].enable, int'(stim_table[r].max_gap));
            end
        end

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        longint limit;
        limit = watchdog_limit_ns();
        #(limit);
        $display("Timeout: stimulus did not finish within %0d ns", limit);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
+incdir+.
crt_test_pkg.sv
sine_quarter_rom.sv
wave_phase_gen.sv
wave_coord_stage.sv
pixel_alternator.sv
sine_pattern_top.sv
tb_sine_pattern.sv

//--- Makefile
# Verilator build and run of the CRT sine pattern testbench

VERILATOR ?= verilator
TOP       ?= tb_sine_pattern
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG := TESTBENCH PASSED
FAIL_MSG := TESTBENCH FAILED

RTL_SOURCES := crt_test_pkg.sv sine_quarter_rom.sv wave_phase_gen.sv \
               wave_coord_stage.sv pixel_alternator.sv sine_pattern_top.sv
TB_SOURCES  := tb_sine_pattern.sv tb_sine_model.svh

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(RTL_SOURCES) $(TB_SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
